//--- src/segDisplay_macros.svh
`ifndef SEG_DISPLAY_MACROS_SVH
`define SEG_DISPLAY_MACROS_SVH

// Mirror registers visible on the display
// Bus word addresses 0..8 land on registers 1..9
`define SEG_NUM_REGS 9

// Width of every mirror register and of the bus data path
`define SEG_DATA_W 32

// Wishbone word address width
// Wide enough for the nine registers plus some unmapped space
`define SEG_ADDR_W 4

// Clocks each digit stays lit before the scan moves on
// Kept small for simulation
// A board build raises this so the refresh lands near a few hundred Hz
`define SEG_DIGIT_DWELL 8

`endif

//--- src/segDisplayPkg.sv
`include "segDisplay_macros.svh"

package segDisplayPkg;

	// Master side of the Wishbone classic bus, 39 bits
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`SEG_ADDR_W-1:0] adr;
		logic [`SEG_DATA_W-1:0] dat;
	} wbReq;

	// Slave side, 33 bits
	// dat only meaningful while ack is high
	typedef struct packed {
		logic                   ack;
		logic [`SEG_DATA_W-1:0] dat;
	} wbRsp;

	// What the encoder should do with the slot
	// Blank keeps the anode scan but lights no segment
	typedef enum logic {
		modeValue = 1'b0,
		modeBlank = 1'b1
	} dispMode;

	// One digit worth of work, scanner to encoder
	typedef struct packed {
		dispMode    mode;
		logic [2:0] digit;
		logic [3:0] nibble;
	} digitSlot;

	// All register contents side by side
	// Entry 0 is register 1
	typedef logic [`SEG_NUM_REGS-1:0][`SEG_DATA_W-1:0] regVector;

endpackage

//--- src/wbRegBank.sv
`timescale 1ns/1ps

`include "segDisplay_macros.svh"

module wbRegBank (
	input  logic                    segmentClock,
	input  logic                    rstN,
	input  segDisplayPkg::wbReq     busReq,
	output segDisplayPkg::wbRsp     busRsp,
	output segDisplayPkg::regVector regs
);

	// Register storage, entry 0 is register 1
	segDisplayPkg::regVector regFile;

	// Bus handshake state
	logic ackQ;
	logic accept;
	logic addrHit;

	// Per-register write strobes
	logic [`SEG_NUM_REGS-1:0] wrEn;

	// Registered read data, travels with ack
	logic [`SEG_DATA_W-1:0] rdDataQ;
	logic [`SEG_DATA_W-1:0] rdDataNext;

	// New transfer seen this cycle
	// Masking with ackQ keeps a held stb from being taken twice
	assign accept = busReq.cyc && busReq.stb && !ackQ;

	// Word addresses past the last register are unmapped
	assign addrHit = (busReq.adr < `SEG_ADDR_W'(`SEG_NUM_REGS));

	// One-hot write decode
	// Unmapped writes raise no strobe but still get acked below
	always_comb begin
		wrEn = '0;
		if (accept && busReq.we && addrHit) begin
			wrEn[busReq.adr] = 1'b1;
		end
	end

	// Read mux, zero for unmapped space
	always_comb begin
		rdDataNext = '0;
		if (addrHit) begin
			rdDataNext = regFile[busReq.adr];
		end
	end

	// Single-cycle ack
	// Rises the cycle after the request shows up, drops the next one
	always_ff @(posedge segmentClock) begin
		if (!rstN) begin
			ackQ <= 1'b0;
		end else begin
			ackQ <= accept;
		end
	end

	// Read data captured on the same edge that raises ack
	always_ff @(posedge segmentClock) begin
		if (accept) begin
			rdDataQ <= rdDataNext;
		end
	end

	// Mirror registers
	// Cleared at reset so the display starts at all zeros
	always_ff @(posedge segmentClock) begin
		if (!rstN) begin
			regFile <= '0;
		end else begin
			for (int i = 0; i < `SEG_NUM_REGS; i++) begin
				if (wrEn[i]) begin
					regFile[i] <= busReq.dat;
				end
			end
		end
	end

	assign busRsp.ack = ackQ;
	assign busRsp.dat = rdDataQ;

	// Display side sees the live contents
	assign regs = regFile;

endmodule

//--- src/digitScanner.sv
`timescale 1ns/1ps

`include "segDisplay_macros.svh"

module digitScanner (
	input  logic                    segmentClock,
	input  logic                    rstN,
	input  logic [3:0]              switches,
	input  segDisplayPkg::regVector regs,
	output segDisplayPkg::digitSlot slot
);

	localparam int Dwell = `SEG_DIGIT_DWELL;

	// Counter must be at least one bit even for a dwell of one
	localparam int CntW = (Dwell > 1) ? $clog2(Dwell) : 1;

	// The reset slot already addresses digit 0 for one extra cycle
	// Starting the count one ahead keeps the first digit at exactly Dwell clocks
	localparam logic [CntW-1:0] StartCnt = CntW'((Dwell > 1) ? 1 : 0);
	localparam logic [CntW-1:0] LastCnt  = CntW'(Dwell - 1);

	// Scan position
	logic [CntW-1:0] dwellCnt;
	logic [2:0]      digitIdx;

	// Switch decode
	logic                   swValid;
	logic [3:0]             selIdx;
	logic [`SEG_DATA_W-1:0] selWord;

	// Next slot, registered below
	segDisplayPkg::digitSlot slotNext;

	// Dwell counter and digit rotation
	// Digit index wraps 7 to 0 on its own
	always_ff @(posedge segmentClock) begin
		if (!rstN) begin
			dwellCnt <= StartCnt;
			digitIdx <= 3'd0;
		end else if (dwellCnt == LastCnt) begin
			dwellCnt <= '0;
			digitIdx <= digitIdx + 3'd1;
		end else begin
			dwellCnt <= dwellCnt + CntW'(1);
		end
	end

	// Switch values 1..9 pick registers 1..9
	// Zero and anything past the last register blank the display
	assign swValid = (switches != 4'd0) && (switches <= 4'(`SEG_NUM_REGS));
	assign selIdx  = switches - 4'd1;

	// Register pick, guarded so an invalid switch never indexes past the end
	always_comb begin
		selWord = '0;
		if (swValid) begin
			selWord = regs[selIdx];
		end
	end

	// Build the slot for the digit currently in focus
	always_comb begin
		slotNext.digit  = digitIdx;
		slotNext.nibble = selWord[{digitIdx, 2'b00} +: 4];
		if (swValid) begin
			slotNext.mode = segDisplayPkg::modeValue;
		end else begin
			slotNext.mode = segDisplayPkg::modeBlank;
		end
	end

	// First pipeline stage, refreshed every clock
	always_ff @(posedge segmentClock) begin
		if (!rstN) begin
			slot.mode   <= segDisplayPkg::modeBlank;
			slot.digit  <= 3'd0;
			slot.nibble <= 4'd0;
		end else begin
			slot <= slotNext;
		end
	end

endmodule

//--- src/segmentEncoder.sv
`timescale 1ns/1ps

module segmentEncoder (
	input  logic                    segmentClock,
	input  logic                    rstN,
	input  segDisplayPkg::digitSlot slot,
	output logic [6:0]              seg,
	output logic [7:0]              an
);

	logic [6:0] segNext;
	logic [7:0] anNext;

	// Hex glyphs, listed lit-high as gfedcba and inverted for the board
	// b and d lower case so they differ from 8 and 0
	function automatic logic [6:0] hexGlyph(input logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'b0111111;
			4'h1: lit = 7'b0000110;
			4'h2: lit = 7'b1011011;
			4'h3: lit = 7'b1001111;
			4'h4: lit = 7'b1100110;
			4'h5: lit = 7'b1101101;
			4'h6: lit = 7'b1111101;
			4'h7: lit = 7'b0000111;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1101111;
			4'hA: lit = 7'b1110111;
			4'hB: lit = 7'b1111100;
			4'hC: lit = 7'b0111001;
			4'hD: lit = 7'b1011110;
			4'hE: lit = 7'b1111001;
			default: lit = 7'b1110001;
		endcase
		return ~lit;
	endfunction

	// Blank mode darkens every segment
	always_comb begin
		if (slot.mode == segDisplayPkg::modeBlank) begin
			segNext = '1;
		end else begin
			segNext = hexGlyph(slot.nibble);
		end
	end

	// One-hot low anode, bit 0 is the rightmost digit
	// Keeps scanning even when blank
	assign anNext = ~(8'd1 << slot.digit);

	// Segments and anode leave on the same edge
	// Stops ghosting of one digit's glyph onto its neighbor
	always_ff @(posedge segmentClock) begin
		if (!rstN) begin
			seg <= '1;
			an  <= '1;
		end else begin
			seg <= segNext;
			an  <= anNext;
		end
	end

endmodule

//--- src/segDisplayTop.sv
`timescale 1ns/1ps

module segDisplayTop (
	input  logic                segmentClock,
	input  logic                rstN,
	input  segDisplayPkg::wbReq busReq,
	output segDisplayPkg::wbRsp busRsp,
	input  logic [3:0]          switches,
	output logic [6:0]          seg,
	output logic [7:0]          an
);

	// Live register contents, bank to scanner
	segDisplayPkg::regVector regs;

	// Registered digit work, scanner to encoder
	segDisplayPkg::digitSlot slot;

	// Bus slave and mirror storage
	wbRegBank regBank (
		.segmentClock(segmentClock),
		.rstN        (rstN),
		.busReq      (busReq),
		.busRsp      (busRsp),
		.regs        (regs)
	);

	// Register pick and digit rotation
	// One cycle from switches and regs to slot
	digitScanner scanner (
		.segmentClock(segmentClock),
		.rstN        (rstN),
		.switches    (switches),
		.regs        (regs),
		.slot        (slot)
	);

	// Glyph lookup and anode decode
	// Second cycle, so pins trail inputs by two clocks
	segmentEncoder encoder (
		.segmentClock(segmentClock),
		.rstN        (rstN),
		.slot        (slot),
		.seg         (seg),
		.an          (an)
	);

endmodule

//--- tests/segDisplayTb.sv
`timescale 1ns/1ps

`include "segDisplay_macros.svh"

module segDisplayTb;

	localparam int MaxRecs = 64;
	localparam int Dwell = `SEG_DIGIT_DWELL;
	localparam int ScanLen = 8 * Dwell;
	localparam int AckTimeout = 16;

	// Pattern opcodes as they appear in the first column
	localparam logic [31:0] OpWrite = 32'h1;
	localparam logic [31:0] OpRead  = 32'h2;
	localparam logic [31:0] OpShow  = 32'h3;
	localparam logic [31:0] OpEnd   = 32'hf;

	logic segmentClock;
	logic rstN;
	segDisplayPkg::wbReq busReq;
	segDisplayPkg::wbRsp busRsp;
	logic [3:0] switches;
	logic [6:0] seg;
	logic [7:0] an;

	// Each record is four words of op, addr, data and switches
	logic [31:0] patMem [4*MaxRecs];
	int numRecs;
	bit loaded;

	// Register copy built from the writes issued
	logic [31:0] model [`SEG_NUM_REGS];

	// Active-low glyphs with bit 0 as segment a
	logic [6:0] glyphTable [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
	};

	int busErrors;
	int displayErrors;
	int scanErrors;
	int fileErrors;

	// Scan monitor state
	bit scanLive;
	logic [7:0] prevAn;
	int runLen;

	segDisplayTop UUT (
		.segmentClock(segmentClock),
		.rstN        (rstN),
		.busReq      (busReq),
		.busRsp      (busRsp),
		.switches    (switches),
		.seg         (seg),
		.an          (an)
	);

	initial segmentClock = 1'b0;
	always #10 segmentClock = ~segmentClock;

	task automatic reportMismatch(input string sigName, input logic [31:0] expVal,
		input logic [31:0] actVal);
		$display("ERR t=%0t %s expected %h got %h", $time, sigName, expVal, actVal);
	endtask

	// One Wishbone classic transfer with its ack timing checked
	task automatic busTransfer(input logic we, input logic [3:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		segDisplayPkg::wbReq req;
		int waitCnt;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.dat = wdata;
		rdata = '0;
		waitCnt = 0;
		@(posedge segmentClock);
		busReq <= req;
		// One edge for the slave to see stb, one more for the registered ack
		do begin
			@(negedge segmentClock);
			waitCnt++;
		end while (!busRsp.ack && waitCnt < AckTimeout);
		if (!busRsp.ack) begin
			$display("Transfer to address %h got no acknowledge in %0d cycles", adr, AckTimeout);
			busErrors++;
		end else begin
			if (waitCnt != 2) begin
				reportMismatch("ack latency", 32'd1, 32'(waitCnt - 1));
				busErrors++;
			end
			rdata = busRsp.dat;
		end
		@(posedge segmentClock);
		busReq <= '0;
		// Ack must be gone after one cycle
		@(negedge segmentClock);
		if (busRsp.ack !== 1'b0) begin
			reportMismatch("busRsp.ack", 32'd0, 32'(busRsp.ack));
			busErrors++;
		end
	endtask

	// Sets the switches and watches one full scan
	task automatic showCheck(input logic [3:0] sw, input logic [31:0] fileWord);
		logic [31:0] shownWord;
		logic [7:0] seenMask;
		logic [6:0] expSeg;
		logic [3:0] nib;
		bit valid;
		int digit;
		int i;
		valid = (sw >= 4'd1) && (sw <= 4'd9);
		shownWord = valid ? model[sw - 4'd1] : 32'd0;
		if (fileWord != shownWord) begin
			reportMismatch("expected display word", fileWord, shownWord);
			fileErrors++;
		end
		@(posedge segmentClock);
		switches <= sw;
		// Two pipeline stages before the pins follow
		repeat (2) @(posedge segmentClock);
		seenMask = '0;
		repeat (ScanLen) begin
			@(negedge segmentClock);
			if ($countones(~an) == 1) begin
				digit = 0;
				for (i = 0; i < 8; i++) begin
					if (!an[i]) digit = i;
				end
				seenMask[digit] = 1'b1;
				nib = shownWord[digit*4 +: 4];
				expSeg = valid ? glyphTable[nib] : 7'h7f;
				if (seg != expSeg) begin
					reportMismatch($sformatf("seg digit %0d", digit), 32'(expSeg), 32'(seg));
					displayErrors++;
				end
			end
		end
		if (seenMask != 8'hff) begin
			$display("Digits not lit during one scan with switches %h, seen mask %b", sw, seenMask);
			displayErrors++;
		end
	endtask

	// Rotation order, dwell time and one-hot anode over the whole run
	always @(negedge segmentClock) begin
		if (rstN) begin
			if (!scanLive) begin
				if (an != 8'hff) begin
					scanLive = 1'b1;
					prevAn = an;
					runLen = 1;
					if (an != 8'hfe) begin
						reportMismatch("first an", 32'h fe, 32'(an));
						scanErrors++;
					end
				end
			end else begin
				if ($countones(~an) != 1) begin
					reportMismatch("an one-hot", 32'(prevAn), 32'(an));
					scanErrors++;
				end
				if (an == prevAn) begin
					runLen++;
				end else begin
					if (runLen != Dwell) begin
						reportMismatch("digit dwell", 32'(Dwell), 32'(runLen));
						scanErrors++;
					end
					// Next digit to the left with 7 wrapping to 0
					if (an != {prevAn[6:0], prevAn[7]}) begin
						reportMismatch("an order", 32'({prevAn[6:0], prevAn[7]}), 32'(an));
						scanErrors++;
					end
					prevAn = an;
					runLen = 1;
				end
			end
		end
	end

	// Watchdog budget per record covers a full scan plus bus overhead
	initial begin
		int limit;
		wait (loaded);
		limit = (numRecs + 1) * (ScanLen + 40);
		repeat (limit) @(posedge segmentClock);
		$display("Run timed out after %0d cycles", limit);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		logic [31:0] op;
		logic [31:0] rdata;
		logic [3:0] adr;
		int rec;
		void'($urandom(32'hb562_fe1a));
		rstN = 1'b0;
		busReq = '0;
		switches = 4'd0;
		busErrors = 0;
		displayErrors = 0;
		scanErrors = 0;
		fileErrors = 0;
		scanLive = 1'b0;
		prevAn = 8'hff;
		runLen = 0;
		for (rec = 0; rec < `SEG_NUM_REGS; rec++) model[rec] = 32'd0;
		$readmemh("tests/displayPatterns.mem", patMem);
		numRecs = 0;
		while (numRecs < MaxRecs && patMem[numRecs*4] !== OpEnd) numRecs++;
		if (numRecs == MaxRecs) begin
			$display("Pattern file has no end marker");
			fileErrors++;
		end
		loaded = 1'b1;

		// Reset held for 16 edges with the outputs dark
		repeat (15) @(posedge segmentClock);
		@(negedge segmentClock);
		if (busRsp.ack !== 1'b0 || an !== 8'hff || seg !== 7'h7f) begin
			reportMismatch("reset {ack,an,seg}", 32'h7fff, 32'({busRsp.ack, an, seg}));
			busErrors++;
		end
		@(posedge segmentClock);
		rstN <= 1'b1;
		@(negedge segmentClock);
		if (busRsp.ack !== 1'b0 || an !== 8'hff || seg !== 7'h7f) begin
			reportMismatch("release {ack,an,seg}", 32'h7fff, 32'({busRsp.ack, an, seg}));
			busErrors++;
		end

		for (rec = 0; rec < numRecs; rec++) begin
			op = patMem[rec*4];
			adr = patMem[rec*4+1][3:0];
			if (op == OpWrite) begin
				busTransfer(1'b1, adr, patMem[rec*4+2], rdata);
				if (adr < 4'(`SEG_NUM_REGS)) model[adr] = patMem[rec*4+2];
			end else if (op == OpRead) begin
				busTransfer(1'b0, adr, 32'd0, rdata);
				if (rdata != patMem[rec*4+2]) begin
					reportMismatch($sformatf("busRsp.dat addr %h", adr), patMem[rec*4+2], rdata);
					busErrors++;
				end
			end else if (op == OpShow) begin
				showCheck(patMem[rec*4+3][3:0], patMem[rec*4+2]);
			end else begin
				$display("Pattern record %0d has unknown opcode %h", rec, op);
				fileErrors++;
			end
			// Idle gap between records
			repeat ($urandom_range(3, 0)) @(posedge segmentClock);
		end

		repeat (4) @(posedge segmentClock);
		$display("Errors: bus %0d, display %0d, scan %0d, pattern %0d",
			busErrors, displayErrors, scanErrors, fileErrors);
		if (busErrors + displayErrors + scanErrors + fileErrors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- tests/displayPatterns.mem
// Columns: op addr data switches, all hex
// op 1 write, 2 read (data is expected), 3 show (data is shown word), f end
3 0 00000000 1
1 0 12345678 0
1 1 9abcdef0 0
1 2 deadbeef 0
1 8 0badf00d 0
2 0 12345678 0
2 1 9abcdef0 0
2 2 deadbeef 0
2 8 0badf00d 0
2 3 00000000 0
// Unmapped space
1 9 ffffffff 0
1 f a5a5a5a5 0
2 9 00000000 0
2 f 00000000 0
2 8 0badf00d 0
2 0 12345678 0
3 0 12345678 1
3 0 9abcdef0 2
3 0 deadbeef 3
3 0 0badf00d 9
// Blank switch values
3 0 00000000 0
3 0 00000000 a
3 0 00000000 f
1 3 c0ffee42 0
3 0 c0ffee42 4
1 3 76543210 0
2 3 76543210 0
3 0 76543210 4
f 0 00000000 0

//--- files.f
+incdir+src
src/segDisplayPkg.sv
src/wbRegBank.sv
src/digitScanner.sv
src/segmentEncoder.sv
src/segDisplayTop.sv
tests/segDisplayTb.sv

//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing
TOP        = segDisplayTb
RTL_TOP    = segDisplayTop
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
